// File: tb.f
exec_pkg.sv
instr_intake.sv
stage_wall.sv
register_file.sv
execute_unit.sv
retire_port.sv
exec_core.sv
tb_exec_core.sv

// File: run.sh
#!/bin/sh
verilator --binary -f tb.f --top-module tb_exec_core -o tb_exec_core \
	&& ./obj_dir/tb_exec_core | grep "TESTBENCH PASSED" \
	|| { echo "simulation did not pass"; exit 1; }

// File: tb_exec_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_exec_core;

	localparam int NUM_INSTR    = 26;
	localparam int RESET_CYCLES = 10;
	localparam int DRAIN_CYCLES = 40;

	logic              clock;
	logic              reset;
	logic              in_req;
	exec_pkg::instr_t  in_instruction;
	logic              in_ack;
	logic              out_req;
	exec_pkg::result_t out_result;
	logic              out_ack;

	exec_pkg::instr_t  program_tab [NUM_INSTR];
	exec_pkg::result_t expect_tab [NUM_INSTR];
	exec_pkg::result_t expect_q [$];
	logic [31:0]       model_regs [32];
	logic [31:0]       model_mem [exec_pkg::DM_WORDS];
	int                seed = 8310;
	int                retired = 0;

	exec_core dut0 (
		.clock(clock), .reset(reset),
		.in_req(in_req), .in_instruction(in_instruction), .in_ack(in_ack),
		.out_req(out_req), .out_result(out_result), .out_ack(out_ack)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// ##########################################################
	// instruction encoders
	// ##########################################################

	function automatic exec_pkg::instr_t alu_word(input logic [4:0] sub, input logic [4:0] rt,
		input logic [4:0] ra, input logic [4:0] rb);
		return {1'b0, exec_pkg::OPC_ALU, rt, ra, rb, 5'd0, sub};
	endfunction

	function automatic exec_pkg::instr_t addi_word(input logic [4:0] rt, input logic [4:0] ra,
		input logic [13:0] imm);
		return {1'b0, exec_pkg::OPC_ADDI, rt, ra, 1'b0, imm};
	endfunction

	function automatic exec_pkg::instr_t movi_word(input logic [4:0] rt, input logic [19:0] imm);
		return {1'b0, exec_pkg::OPC_MOVI, rt, imm};
	endfunction

	function automatic exec_pkg::instr_t mem_word(input logic [7:0] ls, input logic [4:0] rt,
		input logic [4:0] ra, input logic [4:0] rb);
		return {1'b0, exec_pkg::OPC_LSW, rt, ra, rb, 2'b00, ls};
	endfunction

	// ##########################################################
	// reference model
	// ##########################################################

	task automatic model_execute(input exec_pkg::instr_t w, output exec_pkg::result_t r);
		logic [4:0]  rt;
		logic [31:0] a;
		logic [31:0] b;
		rt = w[24:20];
		a  = model_regs[w[19:15]];
		b  = model_regs[w[14:10]];
		r  = '0;
		r.rt = rt;
		case (w[30:25])
			exec_pkg::OPC_ALU: begin
				r.do_reg_write = 1'b1;
				case (w[4:0])
					exec_pkg::SUB_ADD: r.value = a + b;
					exec_pkg::SUB_SUB: r.value = a - b;
					exec_pkg::SUB_AND: r.value = a & b;
					exec_pkg::SUB_OR:  r.value = a | b;
					exec_pkg::SUB_XOR: r.value = a ^ b;
					exec_pkg::SUB_SLT: r.value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default:           r.value = 32'd0;
				endcase
			end
			exec_pkg::OPC_ADDI: begin
				r.do_reg_write = 1'b1;
				r.value = a + {{18{w[13]}}, w[13:0]};
			end
			exec_pkg::OPC_MOVI: begin
				r.do_reg_write = 1'b1;
				r.value = {{12{w[19]}}, w[19:0]};
			end
			exec_pkg::OPC_LSW: begin
				if (w[7:0] == exec_pkg::LS_LW) begin
					r.address      = a + b;
					r.value        = model_mem[r.address[7:2]];
					r.do_reg_write = 1'b1;
				end else if (w[7:0] == exec_pkg::LS_SW) begin
					r.address     = a; // store address is ra alone.
					r.value       = model_regs[rt];
					r.do_dm_write = 1'b1;
					model_mem[a[7:2]] = r.value;
				end
			end
			default: r.value = 32'd0;
		endcase
		if (r.do_reg_write && rt != 5'd0) model_regs[rt] = r.value;
	endtask

	task automatic fill_program();
		program_tab[0]  = movi_word(5'd1, 20'd5);
		program_tab[1]  = movi_word(5'd2, 20'hFFFFD);   // -3.
		program_tab[2]  = movi_word(5'd3, 20'h7FFFF);
		program_tab[3]  = movi_word(5'd4, 20'h80000);   // most negative.
		program_tab[4]  = addi_word(5'd5, 5'd1, 14'h3FFF);
		program_tab[5]  = addi_word(5'd6, 5'd2, 14'd100);
		program_tab[6]  = movi_word(5'd0, 20'd77);      // reported, not kept.
		program_tab[7]  = addi_word(5'd7, 5'd0, 14'd1);
		program_tab[8]  = alu_word(exec_pkg::SUB_ADD, 5'd8, 5'd1, 5'd2);
		program_tab[9]  = alu_word(exec_pkg::SUB_SUB, 5'd9, 5'd1, 5'd2);
		program_tab[10] = alu_word(exec_pkg::SUB_AND, 5'd10, 5'd3, 5'd4);
		program_tab[11] = alu_word(exec_pkg::SUB_OR, 5'd11, 5'd3, 5'd4);
		program_tab[12] = alu_word(exec_pkg::SUB_XOR, 5'd12, 5'd1, 5'd2);
		program_tab[13] = alu_word(exec_pkg::SUB_SLT, 5'd13, 5'd2, 5'd1);
		program_tab[14] = alu_word(exec_pkg::SUB_SLT, 5'd14, 5'd1, 5'd2);
		program_tab[15] = alu_word(exec_pkg::SUB_SLT, 5'd15, 5'd4, 5'd2);
		program_tab[16] = movi_word(5'd16, 20'h40);
		program_tab[17] = mem_word(exec_pkg::LS_SW, 5'd9, 5'd16, 5'd0);
		program_tab[18] = mem_word(exec_pkg::LS_LW, 5'd18, 5'd16, 5'd0);
		program_tab[19] = alu_word(exec_pkg::SUB_ADD, 5'd19, 5'd18, 5'd18); // back to back.
		program_tab[20] = alu_word(exec_pkg::SUB_SUB, 5'd20, 5'd19, 5'd1);
		program_tab[21] = 32'h7E5F_FFFF;                // unknown opcode, rt is r5.
		program_tab[22] = mem_word(8'hFF, 5'd20, 5'd16, 5'd0);
		program_tab[23] = alu_word(exec_pkg::SUB_OR, 5'd21, 5'd5, 5'd20);
		program_tab[24] = mem_word(exec_pkg::LS_LW, 5'd22, 5'd16, 5'd0);
		program_tab[25] = alu_word(exec_pkg::SUB_SLT, 5'd23, 5'd0, 5'd2);
		for (int i = 0; i < 32; i++) model_regs[i] = 32'd0;
		for (int i = 0; i < exec_pkg::DM_WORDS; i++) model_mem[i] = 32'd0;
		for (int i = 0; i < NUM_INSTR; i++) model_execute(program_tab[i], expect_tab[i]);
	endtask

	// ##########################################################
	// checks and handshake drivers
	// ##########################################################

	task automatic report_mismatch(input string field, input int idx, input logic [31:0] got,
		input logic [31:0] want);
		$display("[FAIL] %0t: %s of result %0d is %h, expected %h", $time, field, idx, got, want);
		$display("TESTBENCH FAILED");
		$fatal(1, "result mismatch");
	endtask

	task automatic check_result(input exec_pkg::result_t got, input exec_pkg::result_t want,
		input int idx);
		if (got.rt !== want.rt) report_mismatch("rt", idx, 32'(got.rt), 32'(want.rt));
		if (got.value !== want.value) report_mismatch("value", idx, got.value, want.value);
		if (got.address !== want.address)
			report_mismatch("address", idx, got.address, want.address);
		if (got.do_reg_write !== want.do_reg_write)
			report_mismatch("do_reg_write", idx, 32'(got.do_reg_write), 32'(want.do_reg_write));
		if (got.do_dm_write !== want.do_dm_write)
			report_mismatch("do_dm_write", idx, 32'(got.do_dm_write), 32'(want.do_dm_write));
	endtask

	task automatic send_all();
		int gap;
		for (int i = 0; i < NUM_INSTR; i++) begin
			gap = $unsigned($random(seed)) % 4;
			repeat (gap) @(posedge clock);
			@(posedge clock);
			in_req         <= 1'b1;
			in_instruction <= program_tab[i];
			expect_q.push_back(expect_tab[i]);
			do @(posedge clock); while (!in_ack);
			in_req <= 1'b0;
			do @(posedge clock); while (in_ack);
		end
	endtask

	task automatic answer_results();
		int                delay;
		exec_pkg::result_t want;
		forever begin
			do @(posedge clock); while (!out_req);
			delay = $unsigned($random(seed)) % 7;
			repeat (delay) @(posedge clock);
			if (expect_q.size() == 0) begin
				$display("out_req went high with no instruction outstanding");
				$display("TESTBENCH FAILED");
				$fatal(1, "extra result");
			end else begin
				want = expect_q.pop_front();
				check_result(out_result, want, retired); // out_result holds while req is up.
				out_ack <= 1'b1;
				retired++;
				do @(posedge clock); while (out_req);
				out_ack <= 1'b0;
			end
		end
	endtask

	initial begin
		repeat (RESET_CYCLES + NUM_INSTR * 20) @(posedge clock);
		$display("timeout, only %0d of %0d instructions retired", retired, NUM_INSTR);
		$display("TESTBENCH FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin
		int drain;
		reset          = 1'b1;
		in_req         = 1'b0;
		in_instruction = '0;
		out_ack        = 1'b0;
		fill_program();
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
		fork
			answer_results();
		join_none
		send_all();
		// the last items still in flight drain out here.
		drain = 0;
		while (expect_q.size() != 0 && drain < DRAIN_CYCLES) begin
			@(posedge clock);
			drain++;
		end
		repeat (20) @(posedge clock); // room for a stray extra result.
		if (expect_q.size() != 0) begin
			$display("expected results still queued at the end of the run");
			$display("TESTBENCH FAILED");
			$fatal(1, "results missing");
		end else begin
			$display("TESTBENCH PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: exec_core.sv
`timescale 1ns/1ns
`default_nettype none

module exec_core (
	input  logic              clock,
	input  logic              reset,
	input  logic              in_req,
	input  exec_pkg::instr_t  in_instruction,
	output logic              in_ack,
	output logic              out_req,
	output exec_pkg::result_t out_result,
	input  logic              out_ack
);

	exec_pkg::decoded_t dec_item;
	exec_pkg::decoded_t a_item;
	exec_pkg::result_t  ex_result;
	exec_pkg::result_t  b_item;

	logic        load_a;
	logic        a_valid;
	logic        a_free;
	logic        b_valid;
	logic        b_free;
	logic        pop;
	logic [4:0]  ra_index;
	logic [4:0]  rb_index;
	logic [31:0] ra_data;
	logic [31:0] rb_data;
	logic        wr_en;
	logic [4:0]  wr_index;
	logic [31:0] wr_data;

	instr_intake intake0 (
		.clock(clock), .reset(reset),
		.in_req(in_req), .in_instruction(in_instruction), .in_ack(in_ack),
		.wall_free(a_free), .load_en(load_a), .decoded(dec_item)
	);

	// wall a moves on whenever wall b can take its item.
	stage_wall #(.payload_t(exec_pkg::decoded_t)) wall_a (
		.clock(clock), .reset(reset),
		.load_en(load_a), .pass(b_free), .in_item(dec_item),
		.item(a_item), .valid(a_valid), .free(a_free)
	);

	execute_unit exec0 (
		.clock(clock), .reset(reset),
		.item(a_item), .item_valid(a_valid), .advance(b_free),
		.ra_index(ra_index), .rb_index(rb_index),
		.ra_data(ra_data), .rb_data(rb_data),
		.fwd(b_item), .fwd_valid(b_valid), .result(ex_result)
	);

	register_file regs0 (
		.clock(clock), .reset(reset),
		.ra_index(ra_index), .rb_index(rb_index),
		.ra_data(ra_data), .rb_data(rb_data),
		.write_en(wr_en), .write_index(wr_index), .write_data(wr_data)
	);

	stage_wall #(.payload_t(exec_pkg::result_t)) wall_b (
		.clock(clock), .reset(reset),
		.load_en(a_valid), .pass(pop), .in_item(ex_result),
		.item(b_item), .valid(b_valid), .free(b_free)
	);

	retire_port retire0 (
		.clock(clock), .reset(reset),
		.item(b_item), .item_valid(b_valid), .pop(pop),
		.write_en(wr_en), .write_index(wr_index), .write_data(wr_data),
		.out_req(out_req), .out_ack(out_ack), .out_result(out_result)
	);

endmodule

`default_nettype wire

// File: retire_port.sv
`timescale 1ns/1ns
`default_nettype none

module retire_port (
	input  logic              clock,
	input  logic              reset,
	input  exec_pkg::result_t item,
	input  logic              item_valid,
	output logic              pop,
	output logic              write_en,
	output logic [4:0]        write_index,
	output logic [31:0]       write_data,
	output logic              out_req,
	input  logic              out_ack,
	output exec_pkg::result_t out_result
);

	typedef enum logic {
		ST_IDLE,
		ST_REQ
	} send_state_t;

	send_state_t state;

	// a new send waits until ack from the last one is low.
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: if (item_valid && !out_ack) state <= ST_REQ;
				ST_REQ:  if (out_ack) state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	assign out_req    = (state == ST_REQ);
	assign out_result = item;

	// retire: pop wall b and commit rt on the same edge.
	assign pop         = out_req && out_ack;
	assign write_en    = pop && item.do_reg_write;
	assign write_index = item.rt;
	assign write_data  = item.value;

endmodule

`default_nettype wire

// File: execute_unit.sv
`timescale 1ns/1ns
`default_nettype none

module execute_unit (
	input  logic               clock,
	input  logic               reset,
	input  exec_pkg::decoded_t item,
	input  logic               item_valid,
	input  logic               advance,
	output logic [4:0]         ra_index,
	output logic [4:0]         rb_index,
	input  logic [31:0]        ra_data,
	input  logic [31:0]        rb_data,
	input  exec_pkg::result_t  fwd,
	input  logic               fwd_valid,
	output exec_pkg::result_t  result
);

	localparam int WORD_W = exec_pkg::DM_ADDR_HI - exec_pkg::DM_ADDR_LO + 1;

	logic [31:0]       dmem [exec_pkg::DM_WORDS];
	logic              fwd_live;
	logic [31:0]       a_val;
	logic [31:0]       b_val;
	logic [31:0]       alu_out;
	logic [31:0]       mem_addr;
	logic [WORD_W-1:0] word;
	logic              is_mem;

	// a store reads its data register through the b port.
	assign ra_index = item.ra;
	assign rb_index = item.do_dm_write ? item.rt : item.rb;

	// wall b holds the only write not yet committed.
	assign fwd_live = fwd_valid && fwd.do_reg_write && fwd.rt != 5'd0;
	assign a_val = (fwd_live && fwd.rt == ra_index) ? fwd.value : ra_data;
	assign b_val = (fwd_live && fwd.rt == rb_index) ? fwd.value : rb_data;

	// ##########################################################
	// alu and address
	// ##########################################################

	always_comb begin
		alu_out = 32'd0;
		if (item.opcode == exec_pkg::OPC_ADDI) begin
			alu_out = a_val + item.imm;
		end else begin
			case (item.sub_op_base)
				exec_pkg::SUB_ADD: alu_out = a_val + b_val;
				exec_pkg::SUB_SUB: alu_out = a_val - b_val;
				exec_pkg::SUB_AND: alu_out = a_val & b_val;
				exec_pkg::SUB_OR:  alu_out = a_val | b_val;
				exec_pkg::SUB_XOR: alu_out = a_val ^ b_val;
				exec_pkg::SUB_SLT: alu_out = {31'd0, $signed(a_val) < $signed(b_val)};
				default:           alu_out = 32'd0;
			endcase
		end
	end

	assign is_mem   = item.do_dm_read || item.do_dm_write;
	assign mem_addr = item.do_dm_write ? a_val : a_val + b_val; // store uses ra alone.
	assign word     = mem_addr[exec_pkg::DM_ADDR_HI:exec_pkg::DM_ADDR_LO];

	// data memory, written as the store moves into wall b.
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < exec_pkg::DM_WORDS; i++) begin
				dmem[i] <= 32'd0;
			end
		end else if (item_valid && advance && item.do_dm_write) begin
			dmem[word] <= b_val;
		end
	end

	always_comb begin
		result.rt           = item.rt;
		result.address      = is_mem ? mem_addr : 32'd0;
		result.do_reg_write = item.do_reg_write;
		result.do_dm_write  = item.do_dm_write;
		if (item.do_dm_write) begin
			result.value = b_val;
		end else if (!item.do_reg_write) begin
			result.value = 32'd0;
		end else begin
			case (item.select_write_reg)
				exec_pkg::WSEL_MEM: result.value = dmem[word];
				exec_pkg::WSEL_IMM: result.value = item.imm;
				default:            result.value = alu_out;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: register_file.sv
`timescale 1ns/1ns
`default_nettype none

module register_file (
	input  logic        clock,
	input  logic        reset,
	input  logic [4:0]  ra_index,
	input  logic [4:0]  rb_index,
	output logic [31:0] ra_data,
	output logic [31:0] rb_data,
	input  logic        write_en,
	input  logic [4:0]  write_index,
	input  logic [31:0] write_data
);

	logic [31:0] regs [32];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= 32'd0;
			end
		end else if (write_en && write_index != 5'd0) begin
			regs[write_index] <= write_data;
		end
	end

	// r0 is hard zero.
	assign ra_data = (ra_index == 5'd0) ? 32'd0 : regs[ra_index];
	assign rb_data = (rb_index == 5'd0) ? 32'd0 : regs[rb_index];

endmodule

`default_nettype wire

// File: stage_wall.sv
`timescale 1ns/1ns
`default_nettype none

module stage_wall #(
	parameter type payload_t = logic
) (
	input  logic     clock,
	input  logic     reset,
	input  logic     load_en,
	input  logic     pass,
	input  payload_t in_item,
	output payload_t item,
	output logic     valid,
	output logic     free
);

	logic take;

	assign free = !valid || pass;
	assign take = load_en && free; // never overwrite a held item.

	always_ff @(posedge clock) begin
		if (reset) begin
			valid <= 1'b0;
		end else if (take) begin
			valid <= 1'b1;
		end else if (pass) begin
			valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (take) begin
			item <= in_item;
		end
	end

endmodule

`default_nettype wire

// File: instr_intake.sv
`timescale 1ns/1ns
`default_nettype none

module instr_intake (
	input  logic               clock,
	input  logic               reset,
	input  logic               in_req,
	input  exec_pkg::instr_t   in_instruction,
	output logic               in_ack,
	input  logic               wall_free,
	output logic               load_en,
	output exec_pkg::decoded_t decoded
);

	logic [5:0] opcode;
	logic [7:0] ls_op;

	assign opcode  = in_instruction[exec_pkg::OPC_HI:exec_pkg::OPC_LO];
	assign ls_op   = in_instruction[exec_pkg::LS_HI:exec_pkg::LS_LO];
	assign load_en = in_req && !in_ack && wall_free; // take only on a fresh req.

	// receiving half of the four-phase handshake.
	always_ff @(posedge clock) begin
		if (reset) begin
			in_ack <= 1'b0;
		end else if (load_en) begin
			in_ack <= 1'b1;
		end else if (!in_req) begin
			in_ack <= 1'b0;
		end
	end

	// ##########################################################
	// decoder
	// ##########################################################

	always_comb begin
		decoded.opcode           = opcode;
		decoded.sub_op_base      = in_instruction[exec_pkg::BASE_HI:exec_pkg::BASE_LO];
		decoded.sub_op_ls        = ls_op;
		decoded.ra               = in_instruction[exec_pkg::RA_HI:exec_pkg::RA_LO];
		decoded.rb               = in_instruction[exec_pkg::RB_HI:exec_pkg::RB_LO];
		decoded.rt               = in_instruction[exec_pkg::RT_HI:exec_pkg::RT_LO];
		decoded.imm              = 32'd0;
		decoded.select_write_reg = exec_pkg::WSEL_ALU;
		decoded.do_dm_read       = 1'b0;
		decoded.do_dm_write      = 1'b0;
		decoded.do_reg_write     = 1'b0;
		case (opcode)
			exec_pkg::OPC_ALU: begin
				decoded.do_reg_write = 1'b1;
			end
			exec_pkg::OPC_ADDI: begin
				decoded.imm = {{18{in_instruction[exec_pkg::IMM14_HI]}},
					in_instruction[exec_pkg::IMM14_HI:exec_pkg::IMM14_LO]};
				decoded.do_reg_write = 1'b1;
			end
			exec_pkg::OPC_MOVI: begin
				decoded.imm = {{12{in_instruction[exec_pkg::IMM20_HI]}},
					in_instruction[exec_pkg::IMM20_HI:exec_pkg::IMM20_LO]};
				decoded.select_write_reg = exec_pkg::WSEL_IMM;
				decoded.do_reg_write     = 1'b1;
			end
			exec_pkg::OPC_LSW: begin
				if (ls_op == exec_pkg::LS_LW) begin
					decoded.select_write_reg = exec_pkg::WSEL_MEM;
					decoded.do_dm_read       = 1'b1;
					decoded.do_reg_write     = 1'b1;
				end else if (ls_op == exec_pkg::LS_SW) begin
					decoded.do_dm_write = 1'b1;
				end
			end
			default: begin
				decoded.imm = 32'd0; // no-op, nothing written.
			end
		endcase
	end

endmodule

`default_nettype wire

// File: exec_pkg.sv
`default_nettype none

package exec_pkg;

	// ##########################################################
	// instruction word and field positions
	// ##########################################################

	typedef logic [31:0] instr_t;

	localparam int OPC_HI   = 30;
	localparam int OPC_LO   = 25;
	localparam int RT_HI    = 24;
	localparam int RT_LO    = 20;
	localparam int RA_HI    = 19;
	localparam int RA_LO    = 15;
	localparam int RB_HI    = 14;
	localparam int RB_LO    = 10;
	localparam int LS_HI    = 7;
	localparam int LS_LO    = 0;
	localparam int BASE_HI  = 4;
	localparam int BASE_LO  = 0;
	localparam int IMM14_HI = 13;
	localparam int IMM14_LO = 0;
	localparam int IMM20_HI = 19;
	localparam int IMM20_LO = 0;

	// ##########################################################
	// opcodes and sub-ops
	// ##########################################################

	localparam logic [5:0] OPC_ALU  = 6'b100000;
	localparam logic [5:0] OPC_ADDI = 6'b101000;
	localparam logic [5:0] OPC_MOVI = 6'b100010;
	localparam logic [5:0] OPC_LSW  = 6'b011100;

	localparam logic [4:0] SUB_ADD = 5'b00000;
	localparam logic [4:0] SUB_SUB = 5'b00001;
	localparam logic [4:0] SUB_AND = 5'b00010;
	localparam logic [4:0] SUB_XOR = 5'b00011;
	localparam logic [4:0] SUB_OR  = 5'b00100;
	localparam logic [4:0] SUB_SLT = 5'b00110; // signed.

	localparam logic [7:0] LS_LW = 8'b00000010;
	localparam logic [7:0] LS_SW = 8'b00001010;

	// write source for rt.
	localparam logic [1:0] WSEL_ALU = 2'd0;
	localparam logic [1:0] WSEL_MEM = 2'd1;
	localparam logic [1:0] WSEL_IMM = 2'd2;

	localparam int DM_WORDS   = 64;
	localparam int DM_ADDR_HI = 7; // word index bits of the address.
	localparam int DM_ADDR_LO = 2;

	// ##########################################################
	// stage payloads
	// ##########################################################

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  sub_op_base;
		logic [7:0]  sub_op_ls;
		logic [4:0]  ra;
		logic [4:0]  rb;
		logic [4:0]  rt;
		logic [31:0] imm;
		logic [1:0]  select_write_reg;
		logic        do_dm_read;
		logic        do_dm_write;
		logic        do_reg_write;
	} decoded_t;

	typedef struct packed {
		logic [4:0]  rt;
		logic [31:0] value;   // store data for a store.
		logic [31:0] address;
		logic        do_reg_write;
		logic        do_dm_write;
	} result_t;

endpackage

`default_nettype wire
